// File: Bender.yml
package:
  name: gb_bus

sources:
  - gb_bus_pkg.sv
  - gb_work_ram.sv
  - gb_interrupt_regs.sv
  - gb_addr_decode.sv
  - gb_mmio_execute.sv
  - gb_read_return.sv
  - gb_bus_top.sv
  - target: simulation
    files:
      - tb_gb_bus.sv

// File: gb_addr_decode.sv
// Decode stage of the bus pipeline
// Takes requests and sorts each address into a memory-map region,
// folding the echo range onto work RAM
`timescale 1ns/1ps

module gb_addr_decode (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 advance,
   input  logic                 req_valid,
   input  gb_bus_pkg::bus_req_t req,
   input  logic                 boot_disable,
   output gb_bus_pkg::decoded_t decoded
);
   import gb_bus_pkg::*;

   gb_addr_u req_addr;
   region_e  region;
   logic     in_wram;
   logic     in_echo;

   assign req_addr.full = req.addr;

   assign in_wram = (req_addr.full >= wram_start) && (req_addr.full <= wram_end);
   assign in_echo = (req_addr.full >= echo_start) && (req_addr.full <= echo_end);

   always_comb begin
      if (!boot_disable && (req_addr.full <= boot_rom_end)) begin
         region = reg_boot;
      end else if (req_addr.full <= cart_end) begin
         region = reg_cart;
      end else if (in_wram || in_echo) begin
         region = reg_wram;
      end else if (req_addr.split.page == mmio_page) begin
         // Only three registers live in the high page here
         case (req_addr.split.offset)
            off_if:        region = reg_if;
            off_ie:        region = reg_ie;
            off_bootstrap: region = reg_bootstrap;
            default:       region = reg_none;
         endcase
      end else begin
         region = reg_none;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         decoded <= '0;
      end else if (advance) begin
         decoded.valid     <= req_valid;
         decoded.region    <= region;
         decoded.write     <= req.write;
         decoded.wdata     <= req.wdata;
         decoded.addr      <= req.addr;
         // Echo range maps onto the same RAM bytes through the low address bits
         decoded.wram_addr <= req_addr.full[wram_addr_bits-1:0];
      end
   end

endmodule

// File: gb_bus_pkg.sv
// Shared types and constants for the console bus fabric
// Address and data types, memory-map bounds, high-page offsets,
// interrupt sources, region enum and pipeline stage structs
package gb_bus_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  byte_t;

   // One address word, seen whole or as page and offset
   typedef union packed {
      addr_t full;
      struct packed {
         byte_t page;
         byte_t offset;
      } split;
   } gb_addr_u;

   // Memory map
   localparam addr_t boot_rom_end = 16'h00FF;
   localparam addr_t cart_end     = 16'h7FFF;
   localparam addr_t wram_start   = 16'hC000;
   localparam addr_t wram_end     = 16'hDFFF;
   localparam addr_t echo_start   = 16'hE000;
   localparam addr_t echo_end     = 16'hFDFF;

   // Registers in page FF
   localparam byte_t mmio_page     = 8'hFF;
   localparam byte_t off_if        = 8'h0F;
   localparam byte_t off_bootstrap = 8'h50;
   localparam byte_t off_ie        = 8'hFF;

   localparam int wram_addr_bits = 13;
   localparam int irq_count      = 5;

   typedef logic [irq_count-1:0] irq_t;

   // Interrupt source bit positions
   localparam int irq_vblank = 0;
   localparam int irq_lcdc   = 1;
   localparam int irq_timer  = 2;
   localparam int irq_serial = 3;
   localparam int irq_joypad = 4;

   typedef enum logic [2:0] {
      reg_boot,
      reg_cart,
      reg_wram,
      reg_if,
      reg_ie,
      reg_bootstrap,
      reg_none
   } region_e;

   typedef struct packed {
      addr_t addr;
      logic  write;
      byte_t wdata;
   } bus_req_t;

   typedef struct packed {
      logic                      valid;
      region_e                   region;
      logic                      write;
      byte_t                     wdata;
      addr_t                     addr;
      logic [wram_addr_bits-1:0] wram_addr;
   } decoded_t;

   // Data is the immediate byte, RAM data is merged in later
   typedef struct packed {
      logic    valid;
      logic    read;
      region_e region;
      byte_t   data;
   } exec_t;

endpackage

// File: gb_bus_top.sv
// Top level of the bus fabric
// Decode, execute and result stages with one shared advance,
// request and response handshakes and external ROM ports
`timescale 1ns/1ps

module gb_bus_top (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 req_valid,
   input  gb_bus_pkg::bus_req_t req,
   output logic                 req_ready,
   output logic                 rsp_valid,
   output gb_bus_pkg::byte_t    rsp_data,
   input  logic                 rsp_ready,
   input  gb_bus_pkg::irq_t     irq_req,
   output gb_bus_pkg::irq_t     irq_pending,
   output gb_bus_pkg::addr_t    rom_addr,
   input  gb_bus_pkg::byte_t    boot_data,
   input  gb_bus_pkg::byte_t    cart_data
);
   import gb_bus_pkg::*;

   logic     advance;
   logic     stage_busy;
   logic     boot_disable;
   decoded_t decoded;
   exec_t    exec;

   // Whole pipeline stalls only on an untaken response
   assign advance   = !stage_busy;
   assign req_ready = advance;

   gb_addr_decode addr_decode_inst (
      .clock        (clock),
      .reset        (reset),
      .advance      (advance),
      .req_valid    (req_valid),
      .req          (req),
      .boot_disable (boot_disable),
      .decoded      (decoded)
   );

   gb_mmio_execute mmio_execute_inst (
      .clock        (clock),
      .reset        (reset),
      .advance      (advance),
      .decoded      (decoded),
      .irq_req      (irq_req),
      .irq_pending  (irq_pending),
      .boot_disable (boot_disable),
      .rom_addr     (rom_addr),
      .boot_data    (boot_data),
      .cart_data    (cart_data),
      .exec         (exec)
   );

   gb_read_return read_return_inst (
      .clock      (clock),
      .reset      (reset),
      .advance    (advance),
      .exec       (exec),
      .rsp_ready  (rsp_ready),
      .rsp_valid  (rsp_valid),
      .rsp_data   (rsp_data),
      .stage_busy (stage_busy)
   );

endmodule

// File: gb_interrupt_regs.sv
// Interrupt flag (IF) and enable (IE) registers
// Hardware requests merge into IF every cycle, bus writes load
// both registers, pending is the masked flag set
`timescale 1ns/1ps

module gb_interrupt_regs (
   input  logic              clock,
   input  logic              reset,
   input  gb_bus_pkg::irq_t  irq_req,
   input  logic              if_write,
   input  logic              ie_write,
   input  gb_bus_pkg::byte_t wdata,
   output gb_bus_pkg::irq_t  if_q,
   output gb_bus_pkg::irq_t  ie_q,
   output gb_bus_pkg::irq_t  irq_pending
);
   import gb_bus_pkg::*;

   irq_t if_base;
   irq_t if_next;

   // Bus write first, then requests on top so none is dropped
   always_comb begin
      if_base = if_write ? wdata[irq_count-1:0] : if_q;
      if_next[irq_vblank] = if_base[irq_vblank] | irq_req[irq_vblank];
      if_next[irq_lcdc]   = if_base[irq_lcdc]   | irq_req[irq_lcdc];
      if_next[irq_timer]  = if_base[irq_timer]  | irq_req[irq_timer];
      if_next[irq_serial] = if_base[irq_serial] | irq_req[irq_serial];
      if_next[irq_joypad] = if_base[irq_joypad] | irq_req[irq_joypad];
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_q <= '0;
      end else begin
         if_q <= if_next;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ie_q <= '0;
      end else if (ie_write) begin
         ie_q <= wdata[irq_count-1:0];
      end
   end

   assign irq_pending = if_q & ie_q;

endmodule

// File: gb_mmio_execute.sv
// Execute stage of the bus pipeline
// Commits writes to work RAM, IF, IE and the bootstrap register,
// and picks the read byte from ROM ports, registers or RAM
`timescale 1ns/1ps

module gb_mmio_execute (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 advance,
   input  gb_bus_pkg::decoded_t decoded,
   input  gb_bus_pkg::irq_t     irq_req,
   output gb_bus_pkg::irq_t     irq_pending,
   output logic                 boot_disable,
   output gb_bus_pkg::addr_t    rom_addr,
   input  gb_bus_pkg::byte_t    boot_data,
   input  gb_bus_pkg::byte_t    cart_data,
   output gb_bus_pkg::exec_t    exec
);
   import gb_bus_pkg::*;

   logic  do_access;
   logic  ram_enable;
   logic  if_write;
   logic  ie_write;
   byte_t ram_rdata;
   byte_t bootstrap_q;
   byte_t rom_byte;
   byte_t imm_byte;
   irq_t  if_q;
   irq_t  ie_q;
   exec_t exec_q;

   assign do_access  = advance && decoded.valid;
   assign ram_enable = do_access && (decoded.region == reg_wram);
   assign if_write   = do_access && decoded.write && (decoded.region == reg_if);
   assign ie_write   = do_access && decoded.write && (decoded.region == reg_ie);

   gb_work_ram work_ram_inst (
      .clock  (clock),
      .enable (ram_enable),
      .write  (decoded.write),
      .addr   (decoded.wram_addr),
      .wdata  (decoded.wdata),
      .rdata  (ram_rdata)
   );

   gb_interrupt_regs interrupt_regs_inst (
      .clock       (clock),
      .reset       (reset),
      .irq_req     (irq_req),
      .if_write    (if_write),
      .ie_write    (ie_write),
      .wdata       (decoded.wdata),
      .if_q        (if_q),
      .ie_q        (ie_q),
      .irq_pending (irq_pending)
   );

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         bootstrap_q <= '0;
      end else if (do_access && decoded.write && (decoded.region == reg_bootstrap)) begin
         bootstrap_q <= decoded.wdata;
      end
   end

   assign boot_disable = bootstrap_q[0];
   assign rom_addr     = decoded.addr;

   // Overlay is checked again here, a read may have been decoded
   // while an FF50 write was still in this stage
   assign rom_byte = (!boot_disable && (decoded.addr <= boot_rom_end)) ? boot_data
                                                                       : cart_data;

   always_comb begin
      case (decoded.region)
         reg_boot,
         reg_cart:      imm_byte = rom_byte;
         reg_if:        imm_byte = {{(8 - irq_count){1'b0}}, if_q};
         reg_ie:        imm_byte = {{(8 - irq_count){1'b0}}, ie_q};
         reg_bootstrap: imm_byte = bootstrap_q;
         default:       imm_byte = 8'h00;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         exec_q <= '0;
      end else if (advance) begin
         exec_q.valid  <= decoded.valid;
         exec_q.read   <= !decoded.write;
         exec_q.region <= decoded.region;
         exec_q.data   <= imm_byte;
      end
   end

   // RAM byte comes straight from the RAM output register
   always_comb begin
      exec = exec_q;
      if (exec_q.region == reg_wram) begin
         exec.data = ram_rdata;
      end
   end

endmodule

// File: gb_read_return.sv
// Result stage of the bus pipeline
// Output register for read data and the response handshake
`timescale 1ns/1ps

module gb_read_return (
   input  logic              clock,
   input  logic              reset,
   input  logic              advance,
   input  gb_bus_pkg::exec_t exec,
   input  logic              rsp_ready,
   output logic              rsp_valid,
   output gb_bus_pkg::byte_t rsp_data,
   output logic              stage_busy
);

   logic capture;

   // Writes leave the stage empty
   assign capture = exec.valid && exec.read;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rsp_valid <= 1'b0;
      end else if (advance) begin
         rsp_valid <= capture;
      end
   end

   always_ff @(posedge clock) begin
      if (advance && capture) begin
         rsp_data <= exec.data;
      end
   end

   // Response waiting and the master not taking it this cycle
   assign stage_busy = rsp_valid && !rsp_ready;

endmodule

// File: gb_work_ram.sv
// Work RAM, 8 KiB single port
// Synchronous write, registered read data
`timescale 1ns/1ps

module gb_work_ram (
   input  logic                                clock,
   input  logic                                enable,
   input  logic                                write,
   input  logic [gb_bus_pkg::wram_addr_bits-1:0] addr,
   input  gb_bus_pkg::byte_t                   wdata,
   output gb_bus_pkg::byte_t                   rdata
);
   import gb_bus_pkg::*;

   byte_t mem [0:(1 << wram_addr_bits)-1];

   // Read data holds while the port is idle
   always_ff @(posedge clock) begin
      if (enable) begin
         if (write) begin
            mem[addr] <= wdata;
         end else begin
            rdata <= mem[addr];
         end
      end
   end

endmodule

// File: sim.f
gb_bus_pkg.sv
gb_work_ram.sv
gb_interrupt_regs.sv
gb_addr_decode.sv
gb_mmio_execute.sv
gb_read_return.sv
gb_bus_top.sv
tb_gb_bus.sv

// File: tb_gb_bus.sv
// Testbench for the console bus fabric
// Memory-map reference model, ROM models, response monitor and
// directed plus random traffic with response back-pressure
`timescale 1ns/1ps

module tb_gb_bus;
   import gb_bus_pkg::*;

   typedef struct packed {
      addr_t addr;
      byte_t data;
   } expect_t;

   logic     clock;
   logic     reset;
   logic     req_valid;
   bus_req_t req;
   logic     req_ready;
   logic     rsp_valid;
   byte_t    rsp_data;
   logic     rsp_ready;
   irq_t     irq_req;
   irq_t     irq_pending;
   addr_t    rom_addr;
   byte_t    boot_data;
   byte_t    cart_data;
   logic     stall_on;
   int       error_count;
   int       protocol_errors;

   // Reference model state
   byte_t   shadow [0:65535];
   irq_t    if_m;
   irq_t    ie_m;
   byte_t   boot_m;
   expect_t expected_q [$];

   gb_bus_top gb_bus_top_inst (
      .clock       (clock),
      .reset       (reset),
      .req_valid   (req_valid),
      .req         (req),
      .req_ready   (req_ready),
      .rsp_valid   (rsp_valid),
      .rsp_data    (rsp_data),
      .rsp_ready   (rsp_ready),
      .irq_req     (irq_req),
      .irq_pending (irq_pending),
      .rom_addr    (rom_addr),
      .boot_data   (boot_data),
      .cart_data   (cart_data)
   );

   // Boot ROM is the inverted low byte, cartridge is high XOR low
   assign boot_data = ~rom_addr[7:0];
   assign cart_data = rom_addr[15:8] ^ rom_addr[7:0];

   initial begin
      clock = 1'b0;
      forever #50 clock = ~clock;
   end

   // Random stalls on the response channel
   always @(negedge clock) begin
      if (reset || !stall_on) begin
         rsp_ready = 1'b1;
      end else begin
         rsp_ready = ($urandom_range(3) != 0);
      end
   end

   task automatic check_byte(string name, byte_t actual, byte_t expected);
      if (actual !== expected) begin
         error_count++;
         $display("CHECK FAILED %s: got %02h, expected %02h", name, actual, expected);
      end
   endtask

   task automatic check_irq(string name, irq_t actual, irq_t expected);
      if (actual !== expected) begin
         error_count++;
         $display("CHECK FAILED %s: got %02h, expected %02h", name, actual, expected);
      end
   endtask

   task automatic fail_on_timeout(string what);
      $display("Timed out waiting for %s", what);
      $display("TEST RESULT: FAIL");
      $finish;
   endtask

   // Echo range sits 8 KiB above work RAM
   function automatic addr_t fold(addr_t a);
      return (a >= 16'hE000) ? a - 16'h2000 : a;
   endfunction

   function automatic byte_t model_read(addr_t a);
      if (!boot_m[0] && a <= 16'h00FF) return ~a[7:0];
      if (a <= 16'h7FFF) return a[15:8] ^ a[7:0];
      if (a >= 16'hC000 && a <= 16'hFDFF) return shadow[fold(a)];
      if (a == 16'hFF0F) return {3'b000, if_m};
      if (a == 16'hFFFF) return {3'b000, ie_m};
      if (a == 16'hFF50) return boot_m;
      return 8'h00;
   endfunction

   task automatic model_write(addr_t a, byte_t d);
      if (a >= 16'hC000 && a <= 16'hFDFF) shadow[fold(a)] = d;
      else if (a == 16'hFF0F) if_m = d[4:0];
      else if (a == 16'hFFFF) ie_m = d[4:0];
      else if (a == 16'hFF50) boot_m = d;
   endtask

   // Mostly mapped regions, some unmapped and register addresses
   function automatic addr_t pick_addr();
      int    kind;
      addr_t regs [3] = '{16'hFF0F, 16'hFF50, 16'hFFFF};
      kind = $urandom_range(9);
      case (kind)
         0, 1:       return addr_t'($urandom_range(16'h7FFF));
         2, 3, 4, 5: return addr_t'($urandom_range(16'hDFFF, 16'hC000));
         6:          return addr_t'($urandom_range(16'hFDFF, 16'hE000));
         7:          return regs[$urandom_range(2)];
         8:          return addr_t'($urandom_range(16'hBFFF, 16'h8000));
         default:    return addr_t'($urandom_range(16'hFFFF, 16'hFE00));
      endcase
   endfunction

   // Holds the request until accepted, then updates the model
   task automatic issue(addr_t a, logic wr, byte_t d);
      int      waited;
      expect_t e;
      waited = 0;
      @(negedge clock);
      req_valid = 1'b1;
      req.addr  = a;
      req.write = wr;
      req.wdata = d;
      @(posedge clock);
      while (!req_ready) begin
         waited++;
         if (waited > 100) fail_on_timeout("request acceptance");
         @(posedge clock);
      end
      if (wr) begin
         model_write(a, d);
      end else begin
         e.addr = a;
         e.data = model_read(a);
         expected_q.push_back(e);
      end
   endtask

   task automatic idle();
      @(negedge clock);
      req_valid = 1'b0;
   endtask

   // Waits for all reads, then lets trailing writes leave the pipeline
   task automatic drain();
      int waited;
      waited = 0;
      idle();
      while (expected_q.size() != 0) begin
         waited++;
         if (waited > 200) fail_on_timeout("outstanding read responses");
         @(negedge clock);
      end
      repeat (3) idle();
   endtask

   task automatic pulse_irq(irq_t bits);
      @(negedge clock);
      irq_req = bits;
      @(negedge clock);
      irq_req = '0;
      if_m = if_m | bits;
   endtask

   always @(posedge clock) begin : response_monitor
      expect_t e;
      if (!reset && rsp_valid && rsp_ready) begin
         if (expected_q.size() == 0) begin
            protocol_errors++;
            $display("Response %02h arrived with no read outstanding", rsp_data);
         end else begin
            e = expected_q.pop_front();
            check_byte($sformatf("rsp_data for %04h", e.addr), rsp_data, e.data);
         end
      end
   end

   initial begin
      int    i;
      addr_t a;
      addr_t b;
      irq_t  bits;
      void'($urandom(10757));
      reset = 1'b1;
      req_valid = 1'b0;
      req = '0;
      rsp_ready = 1'b1;
      irq_req = '0;
      stall_on = 1'b0;
      error_count = 0;
      protocol_errors = 0;
      if_m = '0;
      ie_m = '0;
      boot_m = 8'h00;
      repeat (10) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      check_irq("irq_pending", irq_pending, '0);

      // Known pattern in all of work RAM
      for (i = 0; i < 8192; i++) begin
         a = 16'hC000 + addr_t'(i);
         issue(a, 1'b1, a[15:8] ^ a[7:0] ^ 8'h3C);
      end

      // Boot overlay on, then switched off through FF50
      repeat (20) issue(addr_t'($urandom_range(16'h00FF)), 1'b0, 8'h00);
      repeat (20) issue(addr_t'($urandom_range(16'h7FFF, 16'h0100)), 1'b0, 8'h00);
      issue(16'hFF50, 1'b1, 8'h01);
      issue(16'hFF50, 1'b0, 8'h00);
      repeat (20) issue(addr_t'($urandom_range(16'h00FF)), 1'b0, 8'h00);
      drain();

      // Work RAM and echo, read back through the other alias
      stall_on = 1'b1;
      for (i = 0; i < 200; i++) begin
         a = addr_t'($urandom_range(16'hFDFF, 16'hC000));
         issue(a, 1'b1, byte_t'($urandom));
         b = (a >= 16'hE000) ? a - 16'h2000
           : (a <= 16'hDDFF) ? a + 16'h2000 : a;
         issue(b, 1'b0, 8'h00);
      end
      drain();

      // Interrupt flags with the bus idle
      stall_on = 1'b0;
      pulse_irq(irq_t'($urandom_range(31, 1)));
      issue(16'hFF0F, 1'b0, 8'h00);
      bits = irq_t'($urandom_range(31, 1));
      issue(16'hFFFF, 1'b1, {3'b111, bits});
      issue(16'hFFFF, 1'b0, 8'h00);
      drain();
      check_irq("irq_pending", irq_pending, if_m & ie_m);
      issue(16'hFF0F, 1'b1, 8'h00);
      issue(16'hFF0F, 1'b0, 8'h00);
      drain();
      check_irq("irq_pending", irq_pending, if_m & ie_m);

      // ROM writes are dropped, unmapped space reads zero
      for (i = 0; i < 40; i++) begin
         a = addr_t'($urandom_range(16'h7FFF));
         issue(a, 1'b1, byte_t'($urandom));
         issue(a, 1'b0, 8'h00);
         a = addr_t'($urandom_range(16'hBFFF, 16'h8000));
         issue(a, 1'b1, byte_t'($urandom));
         issue(a, 1'b0, 8'h00);
      end

      // Random mix under back-pressure
      stall_on = 1'b1;
      for (i = 0; i < 600; i++) begin
         issue(pick_addr(), ($urandom_range(1) == 1), byte_t'($urandom));
         if ($urandom_range(7) == 0) repeat ($urandom_range(3, 1)) idle();
      end
      drain();

      $display("Errors: %0d value mismatches, %0d protocol errors",
               error_count, protocol_errors);
      if (error_count == 0 && protocol_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
